// ==== hdl/dispatch_pkg.sv ====
package dispatch_pkg;

  // Datapath sizes.
  localparam int insn_width    = 32;
  localparam int gpr_idx_width = 5;
  localparam int gpr_count     = 32;
  localparam int word_width    = 64;

  // Architectural register roles.
  localparam int link_reg = 30;
  localparam int zero_reg = 31;

  // Encoding held in the instruction register after reset.
  localparam logic [insn_width-1:0] nop_insn = 32'hd503_201f;

  // Decoded instructions.
  typedef enum logic [5:0] {
    // Loads, stores and moves.
    OP_STUR, OP_LDUR, OP_LDP, OP_STP,
    OP_MOVZ, OP_MOVK, OP_ADR, OP_ADRP,
    // Conditional selects.
    OP_CSINC, OP_CSINV, OP_CSNEG, OP_CSEL,
    // Integer arithmetic and logic.
    OP_ADD, OP_ADDS, OP_SUB, OP_SUBS,
    OP_ORN, OP_ORR, OP_EOR, OP_AND, OP_ANDS,
    OP_UBFM, OP_SBFM,
    // Control flow and system.
    OP_B, OP_B_COND, OP_BL, OP_BLR, OP_BR,
    OP_CBNZ, OP_CBZ, OP_RET, OP_NOP, OP_HLT,
    // Unknown encoding.
    OP_ERR
  } opcode_t;

  // Target functional unit.
  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_t;

  // Operation performed by the functional unit.
  typedef enum logic [3:0] {
    FU_OP_PLUS,
    FU_OP_MINUS,
    FU_OP_LDUR,
    FU_OP_STUR,
    FU_OP_OR,
    FU_OP_ORN,
    FU_OP_EOR,
    FU_OP_AND,
    FU_OP_UBFM,
    FU_OP_SBFM,
    FU_OP_MOV,
    FU_OP_CSEL,
    FU_OP_CSINC,
    FU_OP_CSINV,
    FU_OP_CSNEG
  } fu_op_t;

  // Arm condition codes, in encoding order.
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

endpackage

// ==== hdl/insn_decoder.sv ====
`timescale 1ns/1ns

module insn_decoder (
  input  logic [dispatch_pkg::insn_width-1:0] insnbits,
  output dispatch_pkg::opcode_t               opcode
);

  import dispatch_pkg::*;

  // First matching pattern wins.
  always_comb begin
    casez (insnbits)
      // Unscaled 64-bit store and load.
      32'b1111_1000_000?_????_????_00??_????_????: opcode = OP_STUR;
      32'b1111_1000_010?_????_????_00??_????_????: opcode = OP_LDUR;
      // Register pair load and store.
      32'b1010_1000_11??_????_????_????_????_????: opcode = OP_LDP;
      32'b1010_1001_00??_????_????_????_????_????: opcode = OP_STP;
      // Wide moves.
      32'b1101_0010_1???_????_????_????_????_????: opcode = OP_MOVZ;
      32'b1111_0010_1???_????_????_????_????_????: opcode = OP_MOVK;
      // PC-relative address, byte and page forms.
      32'b0??1_0000_????_????_????_????_????_????: opcode = OP_ADR;
      32'b1??1_0000_????_????_????_????_????_????: opcode = OP_ADRP;
      // Conditional selects, told apart by op and op2.
      32'b1001_1010_100?_????_????_01??_????_????: opcode = OP_CSINC;
      32'b1101_1010_100?_????_????_00??_????_????: opcode = OP_CSINV;
      32'b1101_1010_100?_????_????_01??_????_????: opcode = OP_CSNEG;
      32'b1001_1010_100?_????_????_00??_????_????: opcode = OP_CSEL;
      // Add and subtract, immediate and shifted register.
      32'b1001_0001_0???_????_????_????_????_????: opcode = OP_ADD;
      32'b1010_1011_000?_????_????_????_????_????: opcode = OP_ADDS;
      32'b1101_0001_0???_????_????_????_????_????: opcode = OP_SUB;
      32'b1110_1011_000?_????_????_????_????_????: opcode = OP_SUBS;
      // Logical operations.
      32'b1010_1010_001?_????_????_????_????_????: opcode = OP_ORN;
      32'b1010_1010_000?_????_????_????_????_????: opcode = OP_ORR;
      32'b1100_1010_000?_????_????_????_????_????: opcode = OP_EOR;
      32'b1001_0010_00??_????_????_????_????_????: opcode = OP_AND;
      32'b1110_1010_000?_????_????_????_????_????: opcode = OP_ANDS;
      // Bitfield moves, behind the shift aliases.
      32'b1101_0011_01??_????_????_????_????_????: opcode = OP_UBFM;
      32'b1001_0011_01??_????_????_????_????_????: opcode = OP_SBFM;
      // Immediate branches.
      32'b0001_01??_????_????_????_????_????_????: opcode = OP_B;
      32'b0101_0100_????_????_????_????_???0_????: opcode = OP_B_COND;
      32'b1001_01??_????_????_????_????_????_????: opcode = OP_BL;
      // Register branches.
      32'b1101_0110_0011_1111_0000_00??_???0_0000: opcode = OP_BLR;
      32'b1101_0110_0001_1111_0000_00??_???0_0000: opcode = OP_BR;
      // Compare and branch.
      32'b1011_0101_????_????_????_????_????_????: opcode = OP_CBNZ;
      32'b1011_0100_????_????_????_????_????_????: opcode = OP_CBZ;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: opcode = OP_RET;
      // hint space, only the plain NOP
      32'b1101_0101_0000_0011_0010_0000_0001_1111: opcode = OP_NOP;
      32'b1101_0100_010?_????_????_????_???0_0000: opcode = OP_HLT;
      default:                                     opcode = OP_ERR;
    endcase
  end

endmodule

// ==== hdl/operand_extract.sv ====
`timescale 1ns/1ns

module operand_extract (
  input  logic [dispatch_pkg::insn_width-1:0]    insnbits,
  input  dispatch_pkg::opcode_t                  opcode,
  output logic [dispatch_pkg::gpr_idx_width-1:0] dst,
  output logic [dispatch_pkg::gpr_idx_width-1:0] src1,
  output logic [dispatch_pkg::gpr_idx_width-1:0] src2,
  output logic [dispatch_pkg::word_width-1:0]    imm,
  output dispatch_pkg::cond_t                    cond
);

  import dispatch_pkg::*;

  // Register indices.
  always_comb begin
    case (opcode)
      OP_BL: dst = gpr_idx_width'(link_reg);
      OP_B, OP_BR, OP_B_COND, OP_BLR, OP_RET,
      OP_NOP, OP_HLT, OP_CBZ, OP_CBNZ, OP_STUR: dst = '0;
      default: dst = insnbits[4:0];
    endcase

    case (opcode)
      // Compare and branch tests Rt.
      OP_CBZ, OP_CBNZ: src1 = insnbits[4:0];
      OP_MOVZ, OP_MOVK, OP_ADR, OP_ADRP,
      OP_B, OP_B_COND, OP_BL, OP_NOP, OP_HLT: src1 = '0;
      default: src1 = insnbits[9:5];
    endcase

    case (opcode)
      // Store data comes from Rt.
      OP_STUR: src2 = insnbits[4:0];
      OP_ADDS, OP_SUBS, OP_ORN, OP_ORR, OP_EOR, OP_ANDS,
      OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG: src2 = insnbits[20:16];
      default: src2 = '0;
    endcase
  end

  // Immediates are zero-extended.
  always_comb begin
    case (opcode)
      OP_LDUR, OP_STUR: imm = word_width'(insnbits[20:12]);
      OP_ADD, OP_SUB, OP_UBFM, OP_SBFM: imm = word_width'(insnbits[21:10]);
      OP_MOVZ, OP_MOVK: imm = word_width'(insnbits[20:5]);
      // immhi then immlo
      OP_ADR: imm = word_width'({insnbits[23:5], insnbits[30:29]});
      OP_ADRP: imm = word_width'({insnbits[23:5], insnbits[30:29], 12'h000});
      default: imm = '0;
    endcase
  end

  // Condition field sits in different places per class.
  always_comb begin
    case (opcode)
      OP_B_COND: cond = cond_t'(insnbits[3:0]);
      OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG: cond = cond_t'(insnbits[15:12]);
      default: cond = COND_EQ;
    endcase
  end

endmodule

// ==== hdl/dispatch.sv ====
`timescale 1ns/1ns

module dispatch (
  input  logic                                   in_clk,
  input  logic                                   in_rst,
  input  logic                                   in_stall,
  input  logic [dispatch_pkg::insn_width-1:0]    in_fetch_insnbits,
  input  logic                                   in_fetch_done,
  output logic                                   done,
  output dispatch_pkg::fu_t                      fu_id,
  output dispatch_pkg::fu_op_t                   fu_op,
  output logic                                   use_imm,
  output logic                                   set_nzcv,
  output logic                                   uses_nzcv,
  output logic [dispatch_pkg::gpr_idx_width-1:0] dst,
  output logic [dispatch_pkg::gpr_idx_width-1:0] src1,
  output logic [dispatch_pkg::gpr_idx_width-1:0] src2,
  output logic [dispatch_pkg::word_width-1:0]    imm,
  output dispatch_pkg::cond_t                    cond
);

  import dispatch_pkg::*;

  logic [insn_width-1:0] insnbits;
  opcode_t               opcode;
  logic                  accept;

  // Fetch holds its word while stalled.
  assign accept = in_fetch_done & ~in_stall;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      insnbits <= nop_insn;
      done     <= 1'b0;
    end else begin
      done <= accept;
      if (accept) begin
        insnbits <= in_fetch_insnbits;
      end
    end
  end

  insn_decoder insn_decoder_i (
    .insnbits (insnbits),
    .opcode   (opcode)
  );

  operand_extract operand_extract_i (
    .insnbits (insnbits),
    .opcode   (opcode),
    .dst      (dst),
    .src1     (src1),
    .src2     (src2),
    .imm      (imm),
    .cond     (cond)
  );

  // Loads and stores go to the LS unit.
  assign fu_id = (opcode inside {OP_LDUR, OP_STUR, OP_LDP, OP_STP}) ? FU_LS : FU_ALU;

  always_comb begin
    case (opcode)
      OP_SUB, OP_SUBS:  fu_op = FU_OP_MINUS;
      OP_LDUR:          fu_op = FU_OP_LDUR;
      OP_STUR:          fu_op = FU_OP_STUR;
      OP_ORN:           fu_op = FU_OP_ORN;
      OP_ORR:           fu_op = FU_OP_OR;
      OP_EOR:           fu_op = FU_OP_EOR;
      OP_AND, OP_ANDS:  fu_op = FU_OP_AND;
      OP_UBFM:          fu_op = FU_OP_UBFM;
      OP_SBFM:          fu_op = FU_OP_SBFM;
      OP_MOVZ, OP_MOVK: fu_op = FU_OP_MOV;
      OP_CSEL:          fu_op = FU_OP_CSEL;
      OP_CSINC:         fu_op = FU_OP_CSINC;
      OP_CSINV:         fu_op = FU_OP_CSINV;
      OP_CSNEG:         fu_op = FU_OP_CSNEG;
      // Address generation and everything else adds.
      default:          fu_op = FU_OP_PLUS;
    endcase
  end

  assign use_imm = opcode inside {OP_LDUR, OP_STUR, OP_LDP, OP_STP, OP_MOVK, OP_MOVZ,
                                  OP_ADR, OP_ADRP, OP_ADD, OP_SUB, OP_AND,
                                  OP_UBFM, OP_SBFM};

  // Flag writers and flag readers.
  assign set_nzcv  = opcode inside {OP_ADDS, OP_SUBS, OP_ANDS};
  assign uses_nzcv = opcode inside {OP_B_COND, OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG};

endmodule

// ==== hdl/gpr_file.sv ====
`timescale 1ns/1ns

module gpr_file (
  input  logic                                   in_clk,
  input  logic                                   in_rst,
  input  logic [dispatch_pkg::gpr_idx_width-1:0] rd_idx_a,
  input  logic [dispatch_pkg::gpr_idx_width-1:0] rd_idx_b,
  input  logic                                   wr_en,
  input  logic [dispatch_pkg::gpr_idx_width-1:0] wr_idx,
  input  logic [dispatch_pkg::word_width-1:0]    wr_val,
  output logic [dispatch_pkg::word_width-1:0]    rd_val_a,
  output logic [dispatch_pkg::word_width-1:0]    rd_val_b
);

  import dispatch_pkg::*;

  logic [word_width-1:0] regs [gpr_count];

  // Zero register first, then bypass of the write in flight.
  function automatic logic [word_width-1:0] read_reg(input logic [gpr_idx_width-1:0] idx);
    if (idx == gpr_idx_width'(zero_reg)) begin
      return '0;
    end else if (wr_en && wr_idx == idx) begin
      return wr_val;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < gpr_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != gpr_idx_width'(zero_reg)) begin
      regs[wr_idx] <= wr_val;
    end
  end

  always_comb begin
    rd_val_a = read_reg(rd_idx_a);
    rd_val_b = read_reg(rd_idx_b);
  end

endmodule

// ==== hdl/dispatch_top.sv ====
`timescale 1ns/1ns

module dispatch_top (
  input  logic                                   in_clk,
  input  logic                                   in_rst,
  // Fetch and core.
  input  logic [dispatch_pkg::insn_width-1:0]    in_fetch_insnbits,
  input  logic                                   in_fetch_done,
  input  logic                                   in_stall,
  // Writeback.
  input  logic                                   in_wb_en,
  input  logic [dispatch_pkg::gpr_idx_width-1:0] in_wb_dst,
  input  logic [dispatch_pkg::word_width-1:0]    in_wb_val,
  // Decoded instruction and its operands.
  output logic                                   out_done,
  output dispatch_pkg::fu_t                      out_fu_id,
  output dispatch_pkg::fu_op_t                   out_fu_op,
  output logic [dispatch_pkg::gpr_idx_width-1:0] out_dst,
  output logic [dispatch_pkg::gpr_idx_width-1:0] out_src1,
  output logic [dispatch_pkg::gpr_idx_width-1:0] out_src2,
  output logic [dispatch_pkg::word_width-1:0]    out_imm,
  output logic                                   out_use_imm,
  output dispatch_pkg::cond_t                    out_cond,
  output logic                                   out_set_nzcv,
  output logic                                   out_uses_nzcv,
  output logic [dispatch_pkg::word_width-1:0]    out_src1_val,
  output logic [dispatch_pkg::word_width-1:0]    out_src2_val
);

  dispatch dispatch_i (
    .in_clk            (in_clk),
    .in_rst            (in_rst),
    .in_stall          (in_stall),
    .in_fetch_insnbits (in_fetch_insnbits),
    .in_fetch_done     (in_fetch_done),
    .done              (out_done),
    .fu_id             (out_fu_id),
    .fu_op             (out_fu_op),
    .use_imm           (out_use_imm),
    .set_nzcv          (out_set_nzcv),
    .uses_nzcv         (out_uses_nzcv),
    .dst               (out_dst),
    .src1              (out_src1),
    .src2              (out_src2),
    .imm               (out_imm),
    .cond              (out_cond)
  );

  // Operands are read in the cycle the decoded fields are valid.
  gpr_file gpr_file_i (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .rd_idx_a (out_src1),
    .rd_idx_b (out_src2),
    .wr_en    (in_wb_en),
    .wr_idx   (in_wb_dst),
    .wr_val   (in_wb_val),
    .rd_val_a (out_src1_val),
    .rd_val_b (out_src2_val)
  );

endmodule

// ==== sim/dispatch_sva.sv ====
`timescale 1ns/1ns

module dispatch_sva (
  input logic                                   in_clk,
  input logic                                   in_rst,
  input logic                                   in_fetch_done,
  input logic                                   in_stall,
  input logic                                   out_done,
  input logic [dispatch_pkg::gpr_idx_width-1:0] out_src1,
  input logic [dispatch_pkg::word_width-1:0]    out_src1_val
);

  import dispatch_pkg::*;

  // Count of failed assertions.
  int unsigned error_count = 0;

  // Reset leaves nothing to report.
  done_low_after_reset: assert property (@(posedge in_clk) in_rst |=> !out_done)
    else begin
      error_count++;
      $error("out_done high in the cycle after reset");
    end

  // Only an accepting edge may raise done.
  done_low_after_idle: assert property (@(posedge in_clk) disable iff (in_rst)
    !(in_fetch_done && !in_stall) |=> !out_done)
    else begin
      error_count++;
      $error("out_done high after a stalled or idle edge");
    end

  src1_zero_reg: assert property (@(posedge in_clk) disable iff (in_rst)
    out_src1 == gpr_idx_width'(zero_reg) |-> out_src1_val == '0)
    else begin
      error_count++;
      $error("register 31 read as nonzero on source 1");
    end

endmodule

// ==== sim/dispatch_tb.sv ====
`timescale 1ns/1ns

module dispatch_tb;

  import dispatch_pkg::*;

  // Expected outputs for one held instruction.
  typedef struct packed {
    fu_t                      fu;
    fu_op_t                   op;
    logic [gpr_idx_width-1:0] dst;
    logic [gpr_idx_width-1:0] src1;
    logic [gpr_idx_width-1:0] src2;
    logic [word_width-1:0]    imm;
    logic                     use_imm;
    cond_t                    cond;
    logic                     set_nzcv;
    logic                     uses_nzcv;
  } fields_t;

  logic                     in_clk = 1'b0;
  logic                     in_rst;
  logic [insn_width-1:0]    in_fetch_insnbits;
  logic                     in_fetch_done;
  logic                     in_stall;
  logic                     in_wb_en;
  logic [gpr_idx_width-1:0] in_wb_dst;
  logic [word_width-1:0]    in_wb_val;
  logic                     out_done;
  fu_t                      out_fu_id;
  fu_op_t                   out_fu_op;
  logic [gpr_idx_width-1:0] out_dst;
  logic [gpr_idx_width-1:0] out_src1;
  logic [gpr_idx_width-1:0] out_src2;
  logic [word_width-1:0]    out_imm;
  logic                     out_use_imm;
  cond_t                    out_cond;
  logic                     out_set_nzcv;
  logic                     out_uses_nzcv;
  logic [word_width-1:0]    out_src1_val;
  logic [word_width-1:0]    out_src2_val;

  logic [15:0]           lfsr = 16'd3497;
  logic [insn_width-1:0] pat_mask [$];
  logic [insn_width-1:0] pat_val [$];
  opcode_t               pat_op [$];
  logic [word_width-1:0] shadow [gpr_count];
  logic [insn_width-1:0] held;
  logic                  prev_accept;
  int                    sent = 0;
  int                    done_seen = 0;
  string                 test_name = "startup";

  always #20 in_clk = ~in_clk;

  dispatch_top dispatch_top_i (.*);

  bind dispatch_top dispatch_sva dispatch_sva_i (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .in_fetch_done (in_fetch_done),
    .in_stall      (in_stall),
    .out_done      (out_done),
    .out_src1      (out_src1),
    .out_src1_val  (out_src1_val)
  );

  // Fibonacci LFSR with taps 16, 14, 13 and 11.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  task automatic add_pattern(input logic [31:0] mask, input logic [31:0] val, input opcode_t op);
    pat_mask.push_back(mask);
    pat_val.push_back(val);
    pat_op.push_back(op);
  endtask

  // Encodings as fixed-bit masks in decode priority order.
  task automatic load_patterns();
    add_pattern(32'hffe0_0c00, 32'hf800_0000, OP_STUR);
    add_pattern(32'hffe0_0c00, 32'hf840_0000, OP_LDUR);
    add_pattern(32'hffc0_0000, 32'ha8c0_0000, OP_LDP);
    add_pattern(32'hffc0_0000, 32'ha900_0000, OP_STP);
    add_pattern(32'hff80_0000, 32'hd280_0000, OP_MOVZ);
    add_pattern(32'hff80_0000, 32'hf280_0000, OP_MOVK);
    add_pattern(32'h9f00_0000, 32'h1000_0000, OP_ADR);
    add_pattern(32'h9f00_0000, 32'h9000_0000, OP_ADRP);
    add_pattern(32'hffe0_0c00, 32'h9a80_0400, OP_CSINC);
    add_pattern(32'hffe0_0c00, 32'hda80_0000, OP_CSINV);
    add_pattern(32'hffe0_0c00, 32'hda80_0400, OP_CSNEG);
    add_pattern(32'hffe0_0c00, 32'h9a80_0000, OP_CSEL);
    add_pattern(32'hff80_0000, 32'h9100_0000, OP_ADD);
    add_pattern(32'hffe0_0000, 32'hab00_0000, OP_ADDS);
    add_pattern(32'hff80_0000, 32'hd100_0000, OP_SUB);
    add_pattern(32'hffe0_0000, 32'heb00_0000, OP_SUBS);
    add_pattern(32'hffe0_0000, 32'haa20_0000, OP_ORN);
    add_pattern(32'hffe0_0000, 32'haa00_0000, OP_ORR);
    add_pattern(32'hffe0_0000, 32'hca00_0000, OP_EOR);
    add_pattern(32'hffc0_0000, 32'h9200_0000, OP_AND);
    add_pattern(32'hffe0_0000, 32'hea00_0000, OP_ANDS);
    add_pattern(32'hffc0_0000, 32'hd340_0000, OP_UBFM);
    add_pattern(32'hffc0_0000, 32'h9340_0000, OP_SBFM);
    add_pattern(32'hfc00_0000, 32'h1400_0000, OP_B);
    add_pattern(32'hff00_0010, 32'h5400_0000, OP_B_COND);
    add_pattern(32'hfc00_0000, 32'h9400_0000, OP_BL);
    add_pattern(32'hffff_fc1f, 32'hd63f_0000, OP_BLR);
    add_pattern(32'hffff_fc1f, 32'hd61f_0000, OP_BR);
    add_pattern(32'hff00_0000, 32'hb500_0000, OP_CBNZ);
    add_pattern(32'hff00_0000, 32'hb400_0000, OP_CBZ);
    add_pattern(32'hffff_fc1f, 32'hd65f_0000, OP_RET);
    add_pattern(32'hffff_ffff, 32'hd503_201f, OP_NOP);
    add_pattern(32'hffe0_001f, 32'hd440_0000, OP_HLT);
  endtask

  function automatic opcode_t match_opcode(input logic [31:0] w);
    for (int i = 0; i < pat_val.size(); i++) begin
      if ((w & pat_mask[i]) == pat_val[i]) begin
        return pat_op[i];
      end
    end
    return OP_ERR;
  endfunction

  function automatic fields_t decode_ref(input logic [31:0] w);
    fields_t f;
    opcode_t op;
    op = match_opcode(w);
    f.fu = (op inside {OP_LDUR, OP_STUR, OP_LDP, OP_STP}) ? FU_LS : FU_ALU;
    case (op)
      OP_SUB, OP_SUBS:  f.op = FU_OP_MINUS;
      OP_LDUR:          f.op = FU_OP_LDUR;
      OP_STUR:          f.op = FU_OP_STUR;
      OP_ORN:           f.op = FU_OP_ORN;
      OP_ORR:           f.op = FU_OP_OR;
      OP_EOR:           f.op = FU_OP_EOR;
      OP_AND, OP_ANDS:  f.op = FU_OP_AND;
      OP_UBFM:          f.op = FU_OP_UBFM;
      OP_SBFM:          f.op = FU_OP_SBFM;
      OP_MOVZ, OP_MOVK: f.op = FU_OP_MOV;
      OP_CSEL:          f.op = FU_OP_CSEL;
      OP_CSINC:         f.op = FU_OP_CSINC;
      OP_CSINV:         f.op = FU_OP_CSINV;
      OP_CSNEG:         f.op = FU_OP_CSNEG;
      default:          f.op = FU_OP_PLUS;
    endcase
    if (op == OP_BL) begin
      f.dst = 5'(link_reg);
    end else if (op inside {OP_B, OP_BR, OP_B_COND, OP_BLR, OP_RET, OP_NOP, OP_HLT,
                            OP_CBZ, OP_CBNZ, OP_STUR}) begin
      f.dst = '0;
    end else begin
      f.dst = w[4:0];
    end
    if (op inside {OP_CBZ, OP_CBNZ}) begin
      f.src1 = w[4:0];
    end else if (op inside {OP_MOVZ, OP_MOVK, OP_ADR, OP_ADRP, OP_B, OP_B_COND, OP_BL,
                            OP_NOP, OP_HLT}) begin
      f.src1 = '0;
    end else begin
      f.src1 = w[9:5];
    end
    f.src2 = '0;
    if (op == OP_STUR) begin
      f.src2 = w[4:0];
    end else if (op inside {OP_ADDS, OP_SUBS, OP_ORN, OP_ORR, OP_EOR, OP_ANDS, OP_CSEL,
                            OP_CSINC, OP_CSINV, OP_CSNEG}) begin
      f.src2 = w[20:16];
    end
    // ADR packs immhi above the two immlo bits.
    case (op)
      OP_LDUR, OP_STUR:                 f.imm = 64'(w[20:12]);
      OP_ADD, OP_SUB, OP_UBFM, OP_SBFM: f.imm = 64'(w[21:10]);
      OP_MOVZ, OP_MOVK:                 f.imm = 64'(w[20:5]);
      OP_ADR:                           f.imm = (64'(w[23:5]) << 2) | 64'(w[30:29]);
      OP_ADRP:                          f.imm = ((64'(w[23:5]) << 2) | 64'(w[30:29])) << 12;
      default:                          f.imm = '0;
    endcase
    f.use_imm = op inside {OP_LDUR, OP_STUR, OP_LDP, OP_STP, OP_MOVK, OP_MOVZ, OP_ADR,
                           OP_ADRP, OP_ADD, OP_SUB, OP_AND, OP_UBFM, OP_SBFM};
    f.cond = COND_EQ;
    if (op == OP_B_COND) begin
      f.cond = cond_t'(w[3:0]);
    end else if (op inside {OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG}) begin
      f.cond = cond_t'(w[15:12]);
    end
    f.set_nzcv  = op inside {OP_ADDS, OP_SUBS, OP_ANDS};
    f.uses_nzcv = op inside {OP_B_COND, OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG};
    return f;
  endfunction

  // Register 31 reads zero; a write in flight is seen at once.
  function automatic logic [word_width-1:0] expect_read(input logic [gpr_idx_width-1:0] idx);
    if (idx == 5'(zero_reg)) begin
      return '0;
    end else if (in_wb_en && in_wb_dst == idx) begin
      return in_wb_val;
    end
    return shadow[idx];
  endfunction

  task automatic end_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic check_fu(input string what, input fu_t exp, input fu_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %s, actual %s", test_name, what, exp.name(),
               act.name());
      end_with_failure();
    end
  endtask

  task automatic check_fu_op(input string what, input fu_op_t exp, input fu_op_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %s, actual %s", test_name, what, exp.name(),
               act.name());
      end_with_failure();
    end
  endtask

  task automatic check_cond(input string what, input cond_t exp, input cond_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %s, actual %s", test_name, what, exp.name(),
               act.name());
      end_with_failure();
    end
  endtask

  task automatic check_idx(input string what, input logic [gpr_idx_width-1:0] exp,
                           input logic [gpr_idx_width-1:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_word(input string what, input logic [word_width-1:0] exp,
                            input logic [word_width-1:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_outputs();
    fields_t e;
    e = decode_ref(held);
    check_bit("out_done", prev_accept, out_done);
    check_fu("out_fu_id", e.fu, out_fu_id);
    check_fu_op("out_fu_op", e.op, out_fu_op);
    check_idx("out_dst", e.dst, out_dst);
    check_idx("out_src1", e.src1, out_src1);
    check_idx("out_src2", e.src2, out_src2);
    check_word("out_imm", e.imm, out_imm);
    check_bit("out_use_imm", e.use_imm, out_use_imm);
    check_cond("out_cond", e.cond, out_cond);
    check_bit("out_set_nzcv", e.set_nzcv, out_set_nzcv);
    check_bit("out_uses_nzcv", e.uses_nzcv, out_uses_nzcv);
    check_word("out_src1_val", expect_read(e.src1), out_src1_val);
    check_word("out_src2_val", expect_read(e.src2), out_src2_val);
  endtask

  always @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < gpr_count; i++) begin
        shadow[i] <= '0;
      end
    end else if (in_wb_en) begin
      shadow[in_wb_dst] <= in_wb_val;
    end
  end

  // Outputs are sampled at the edge, before the DUT updates them.
  always @(posedge in_clk) begin
    if (in_rst) begin
      held = nop_insn;
      prev_accept = 1'b0;
    end else begin
      check_outputs();
      if (out_done) begin
        done_seen++;
      end
      prev_accept = in_fetch_done && !in_stall;
      if (prev_accept) begin
        held = in_fetch_insnbits;
      end
    end
  end

  always @(dispatch_top_i.dispatch_sva_i.error_count) begin
    if (dispatch_top_i.dispatch_sva_i.error_count != 0) begin
      $display("Assertion failed in %s, see the error above", test_name);
      end_with_failure();
    end
  end

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    while (done_seen < sent && cycles < 10) begin
      @(negedge in_clk);
      cycles++;
    end
    if (done_seen < sent) begin
      $display("Timeout in %s: out_done never rose for an accepted instruction", test_name);
      end_with_failure();
    end
  endtask

  task automatic send_insn(input logic [insn_width-1:0] word);
    @(negedge in_clk);
    in_fetch_insnbits = word;
    in_fetch_done = 1'b1;
    sent++;
    @(negedge in_clk);
    in_fetch_done = 1'b0;
    wait_for_done();
  endtask

  function automatic logic [31:0] template_word(input int idx);
    return pat_val[idx] | (32'(rand_bits(32)) & ~pat_mask[idx]);
  endfunction

  function automatic logic [31:0] orr_word(input logic [4:0] rd, input logic [4:0] rn,
                                           input logic [4:0] rm);
    return 32'haa00_0000 | {11'b0, rm, 6'b0, rn, rd};
  endfunction

  initial begin
    in_rst = 1'b1;
    in_fetch_insnbits = '0;
    in_fetch_done = 1'b0;
    in_stall = 1'b0;
    in_wb_en = 1'b0;
    in_wb_dst = '0;
    in_wb_val = '0;
    load_patterns();
    repeat (2) @(negedge in_clk);
    in_rst = 1'b0;

    test_name = "reset";
    repeat (4) @(negedge in_clk);

    test_name = "decode";
    for (int i = 0; i < pat_val.size(); i++) begin
      send_insn(template_word(i));
    end
    for (int i = 0; i < 40; i++) begin
      send_insn(32'(rand_bits(32)));
    end

    test_name = "stall";
    send_insn(orr_word(5'd1, 5'd2, 5'd3));
    @(negedge in_clk);
    in_stall = 1'b1;
    in_fetch_insnbits = template_word(13);
    in_fetch_done = 1'b1;
    repeat (3) @(negedge in_clk);
    in_stall = 1'b0;
    sent++;
    @(negedge in_clk);
    in_fetch_done = 1'b0;
    wait_for_done();

    test_name = "back to back";
    @(negedge in_clk);
    for (int i = 0; i < 6; i++) begin
      in_fetch_insnbits = template_word(int'(rand_bits(5)));
      in_fetch_done = 1'b1;
      sent++;
      @(negedge in_clk);
    end
    in_fetch_done = 1'b0;
    wait_for_done();

    test_name = "register write";
    for (int r = 0; r < gpr_count; r++) begin
      @(negedge in_clk);
      in_wb_en = 1'b1;
      in_wb_dst = 5'(r);
      in_wb_val = rand_bits(64);
    end
    @(negedge in_clk);
    in_wb_en = 1'b0;

    test_name = "register read";
    for (int r = 0; r < gpr_count; r++) begin
      send_insn(orr_word(5'(rand_bits(5)), 5'(r), 5'(31 - r)));
    end

    // Writes land on the indices that the held ORR reads.
    test_name = "write-through";
    send_insn(orr_word(5'd0, 5'd9, 5'd10));
    @(negedge in_clk);
    in_wb_en = 1'b1;
    in_wb_dst = 5'd9;
    in_wb_val = rand_bits(64);
    @(negedge in_clk);
    in_wb_dst = 5'd10;
    in_wb_val = rand_bits(64);
    @(negedge in_clk);
    in_wb_dst = 5'd31;
    in_wb_val = '1;
    @(negedge in_clk);
    in_wb_en = 1'b0;

    test_name = "zero register";
    send_insn(32'hb400_0000 | 32'd31);
    send_insn(orr_word(5'd3, 5'd31, 5'd31));

    @(negedge in_clk);
    if (dispatch_top_i.dispatch_sva_i.error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Assertion failures were reported by the bound checker");
      end_with_failure();
    end
  end

endmodule

// ==== sources.f ====
hdl/dispatch_pkg.sv
hdl/insn_decoder.sv
hdl/operand_extract.sv
hdl/dispatch.sv
hdl/gpr_file.sv
hdl/dispatch_top.sv
sim/dispatch_sva.sv
sim/dispatch_tb.sv

// ==== Bender.yml ====
package:
  name: dispatch

sources:
  - hdl/dispatch_pkg.sv
  - hdl/insn_decoder.sv
  - hdl/operand_extract.sv
  - hdl/dispatch.sv
  - hdl/gpr_file.sv
  - hdl/dispatch_top.sv
  - target: simulation
    files:
      - sim/dispatch_sva.sv
      - sim/dispatch_tb.sv
